/* verilog/system_pkg.sv */
////////////////////
// System types for boot straps, fan control and RTC divider
// Default values for the board glue parameters
////////////////////

`default_nettype none

package system_pkg;

  ////////////////////
  // Types
  ////////////////////

  // Boot mode selector, same encoding for host and safety island
  typedef logic [1:0] boot_mode_t;

  // Fan speed from switches, 0 is off and 15 is almost full
  typedef logic [3:0] fan_level_t;
  typedef logic [3:0] fan_step_t;

  typedef logic [4:0] rtc_count_t;

  ////////////////////
  // Defaults
  ////////////////////

  // 10 MHz in, toggle every 5 cycles gives 1 MHz
  localparam int unsigned RtcDividerDefault  = 4;
  localparam int unsigned FanPrescaleDefault = 4;
  localparam int unsigned ResetStagesDefault = 2;

endpackage

`default_nettype wire

/* verilog/pads_pkg.sv */
////////////////////
// Pad-side types for the SPI host and the SD card pins
////////////////////

`default_nettype none

package pads_pkg;

  // Active-low chip selects of the SPI host
  typedef logic [1:0] spi_cs_t;

  // Data lanes, lane 0 is MOSI and lane 1 is MISO in single mode
  typedef logic [3:0] spi_lanes_t;

endpackage

`default_nettype wire

/* verilog/reset_sync.sv */
////////////////////
// Reset merge and release synchronizer
// Board reset and debug reset, test-mode bypass
////////////////////

`timescale 1ns/1ns
`default_nettype none

module reset_sync #(
  parameter int unsigned ResetStages = 2
) (
  input  wire logic clk_10,
  input  wire logic rst_n,
  input  wire logic dbg_reset_i,
  input  wire logic testmode_i,
  output logic      soc_rst_no
);

  logic                   rst_merged_n;
  logic [ResetStages-1:0] sync_q;

  // Either source asserts the reset
  assign rst_merged_n = rst_n & ~dbg_reset_i;

  // Asserts at once, releases after ResetStages edges
  always_ff @(posedge clk_10, negedge rst_merged_n) begin
    if (!rst_merged_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= (sync_q << 1) | 1'b1;
    end
  end

  // In test mode the pad reset drives the core directly
  assign soc_rst_no = testmode_i ? rst_n : sync_q[ResetStages-1];

endmodule

`default_nettype wire

/* verilog/boot_strap_latch.sv */
////////////////////
// Boot-mode strap latch for host and safety island
////////////////////

`timescale 1ns/1ns
`default_nettype none

module boot_strap_latch (
  input  wire logic                   clk_10,
  input  wire logic                   soc_rst_ni,
  input  wire system_pkg::boot_mode_t boot_mode_i,
  input  wire system_pkg::boot_mode_t dbg_boot_mode_i,
  input  wire system_pkg::boot_mode_t boot_mode_safety_i,
  input  wire system_pkg::boot_mode_t dbg_boot_mode_safety_i,
  output system_pkg::boot_mode_t      boot_mode_o,
  output system_pkg::boot_mode_t      boot_mode_safety_o
);

  logic                   captured_q;
  system_pkg::boot_mode_t boot_mode_q;
  system_pkg::boot_mode_t boot_mode_safety_q;

  // Switch straps merged with debug overrides
  system_pkg::boot_mode_t boot_mode_merged;
  system_pkg::boot_mode_t boot_mode_safety_merged;

  assign boot_mode_merged        = boot_mode_i | dbg_boot_mode_i;
  assign boot_mode_safety_merged = boot_mode_safety_i | dbg_boot_mode_safety_i;

  // Sample once on the first edge out of reset, then freeze
  always_ff @(posedge clk_10, negedge soc_rst_ni) begin
    if (!soc_rst_ni) begin
      captured_q         <= 1'b0;
      boot_mode_q        <= '0;
      boot_mode_safety_q <= '0;
    end else if (!captured_q) begin
      captured_q         <= 1'b1;
      boot_mode_q        <= boot_mode_merged;
      boot_mode_safety_q <= boot_mode_safety_merged;
    end
  end

  assign boot_mode_o        = boot_mode_q;
  assign boot_mode_safety_o = boot_mode_safety_q;

endmodule

`default_nettype wire

/* verilog/rtc_divider.sv */
////////////////////
// Real-time clock divider from clk_10
////////////////////

`timescale 1ns/1ns
`default_nettype none

module rtc_divider #(
  parameter int unsigned RtcDivider = 4
) (
  input  wire logic clk_10,
  input  wire logic soc_rst_ni,
  output logic      rtc_clk_o
);

  system_pkg::rtc_count_t count_q;
  logic                   rtc_clk_q;
  logic                   wrap;

  assign wrap = (count_q == system_pkg::rtc_count_t'(RtcDivider));

  // Half period is RtcDivider+1 cycles
  always_ff @(posedge clk_10, negedge soc_rst_ni) begin
    if (!soc_rst_ni) begin
      count_q   <= '0;
      rtc_clk_q <= 1'b0;
    end else if (wrap) begin
      count_q   <= '0;
      rtc_clk_q <= ~rtc_clk_q;
    end else begin
      count_q   <= count_q + 1'b1;
    end
  end

  assign rtc_clk_o = rtc_clk_q;

endmodule

`default_nettype wire

/* verilog/fan_pwm.sv */
////////////////////
// Fan PWM with prescaler, 16 steps per period
////////////////////

`timescale 1ns/1ns
`default_nettype none

module fan_pwm #(
  parameter int unsigned FanPrescale = 4
) (
  input  wire logic                   clk_10,
  input  wire logic                   soc_rst_ni,
  input  wire system_pkg::fan_level_t fan_level_i,
  output logic                        fan_pwm_o
);

  localparam int unsigned PreW = (FanPrescale > 1) ? $clog2(FanPrescale) : 1;

  logic [PreW-1:0]        pre_q;
  logic                   step_end;
  system_pkg::fan_step_t  step_q;
  system_pkg::fan_level_t level_q;
  logic                   pwm_q;

  assign step_end = (pre_q == PreW'(FanPrescale - 1));

  ////////////////////
  // Step timing
  ////////////////////

  always_ff @(posedge clk_10, negedge soc_rst_ni) begin
    if (!soc_rst_ni) begin
      pre_q   <= '0;
      step_q  <= '0;
      level_q <= '0;
    end else if (step_end) begin
      pre_q  <= '0;
      step_q <= step_q + 1'b1;
      // Switches are taken over only when wrapping into step 0
      if (step_q == '1) begin
        level_q <= fan_level_i;
      end
    end else begin
      pre_q <= pre_q + 1'b1;
    end
  end

  // High while the step is below the setting
  always_ff @(posedge clk_10, negedge soc_rst_ni) begin
    if (!soc_rst_ni) begin
      pwm_q <= 1'b0;
    end else begin
      pwm_q <= (step_q < level_q);
    end
  end

  assign fan_pwm_o = pwm_q;

endmodule

`default_nettype wire

/* verilog/sd_pad_ctrl.sv */
////////////////////
// SPI host to SD card pads in SPI mode
// Card detect synchronizer
////////////////////

`timescale 1ns/1ns
`default_nettype none

module sd_pad_ctrl (
  input  wire logic                 clk_10,
  input  wire logic                 soc_rst_ni,
  input  wire logic                 spi_sck_i,
  input  wire logic                 spi_sck_en_i,
  input  wire pads_pkg::spi_cs_t    spi_cs_i,
  input  wire pads_pkg::spi_cs_t    spi_cs_en_i,
  input  wire pads_pkg::spi_lanes_t spi_sd_i,
  input  wire pads_pkg::spi_lanes_t spi_sd_en_i,
  output pads_pkg::spi_lanes_t      spi_sd_o,
  input  wire logic                 sd_cd_i,
  input  wire logic                 sd_dat0_i,
  output logic                      sd_sclk_o,
  output logic                      sd_cmd_o,
  output logic                      sd_dat3_o,
  output logic                      card_present_o
);

  logic [1:0] cd_sync_q;
  logic       card_present;

  ////////////////////
  // Card detect
  ////////////////////

  // Pin is asynchronous to clk_10
  always_ff @(posedge clk_10, negedge soc_rst_ni) begin
    if (!soc_rst_ni) begin
      cd_sync_q <= '0;
    end else begin
      cd_sync_q <= {cd_sync_q[0], sd_cd_i};
    end
  end

  assign card_present   = cd_sync_q[1];
  assign card_present_o = card_present;

  ////////////////////
  // Pin mapping
  ////////////////////

  // All SD pins idle high when the host does not drive them
  assign sd_sclk_o = spi_sck_en_i ? spi_sck_i : 1'b1;

  // DAT3 is chip select, only CS0 reaches the card
  assign sd_dat3_o = (spi_cs_en_i[0] && card_present) ? spi_cs_i[0] : 1'b1;

  // MOSI on CMD
  assign sd_cmd_o = spi_sd_en_i[0] ? spi_sd_i[0] : 1'b1;

  // MISO comes back on DAT0, other lanes read as zero
  assign spi_sd_o = {2'b00, sd_dat0_i, 1'b0};

endmodule

`default_nettype wire

/* verilog/board_glue_top.sv */
////////////////////
// Board glue top level
// Reset, boot straps, RTC, fan PWM and SD pads
////////////////////

`timescale 1ns/1ns
`default_nettype none

module board_glue_top #(
  parameter int unsigned RtcDivider  = system_pkg::RtcDividerDefault,
  parameter int unsigned FanPrescale = system_pkg::FanPrescaleDefault,
  parameter int unsigned ResetStages = system_pkg::ResetStagesDefault
) (
  input  wire logic                   clk_10,
  input  wire logic                   rst_n,
  input  wire logic                   dbg_reset_i,
  input  wire logic                   testmode_i,
  output logic                        soc_rst_no,
  // Boot straps
  input  wire system_pkg::boot_mode_t boot_mode_i,
  input  wire system_pkg::boot_mode_t dbg_boot_mode_i,
  input  wire system_pkg::boot_mode_t boot_mode_safety_i,
  input  wire system_pkg::boot_mode_t dbg_boot_mode_safety_i,
  output system_pkg::boot_mode_t      boot_mode_o,
  output system_pkg::boot_mode_t      boot_mode_safety_o,
  // RTC and fan
  output logic                        rtc_clk_o,
  input  wire system_pkg::fan_level_t fan_sw_i,
  output logic                        fan_pwm_o,
  // SPI host side
  input  wire logic                   spi_sck_i,
  input  wire logic                   spi_sck_en_i,
  input  wire pads_pkg::spi_cs_t      spi_cs_i,
  input  wire pads_pkg::spi_cs_t      spi_cs_en_i,
  input  wire pads_pkg::spi_lanes_t   spi_sd_i,
  input  wire pads_pkg::spi_lanes_t   spi_sd_en_i,
  output pads_pkg::spi_lanes_t        spi_sd_o,
  // SD card side
  input  wire logic                   sd_cd_i,
  input  wire logic                   sd_dat0_i,
  output logic                        sd_sclk_o,
  output logic                        sd_cmd_o,
  output logic                        sd_dat3_o,
  output logic                        card_present_o
);

  ////////////////////
  // Reset
  ////////////////////

  // soc_rst_no resets every other block
  reset_sync #(
    .ResetStages (ResetStages)
  ) i_reset_sync (
    .clk_10      (clk_10),
    .rst_n       (rst_n),
    .dbg_reset_i (dbg_reset_i),
    .testmode_i  (testmode_i),
    .soc_rst_no  (soc_rst_no)
  );

  boot_strap_latch i_boot_strap_latch (
    .clk_10                 (clk_10),
    .soc_rst_ni             (soc_rst_no),
    .boot_mode_i            (boot_mode_i),
    .dbg_boot_mode_i        (dbg_boot_mode_i),
    .boot_mode_safety_i     (boot_mode_safety_i),
    .dbg_boot_mode_safety_i (dbg_boot_mode_safety_i),
    .boot_mode_o            (boot_mode_o),
    .boot_mode_safety_o     (boot_mode_safety_o)
  );

  ////////////////////
  // Clocks and fan
  ////////////////////

  rtc_divider #(
    .RtcDivider (RtcDivider)
  ) i_rtc_divider (
    .clk_10     (clk_10),
    .soc_rst_ni (soc_rst_no),
    .rtc_clk_o  (rtc_clk_o)
  );

  fan_pwm #(
    .FanPrescale (FanPrescale)
  ) i_fan_pwm (
    .clk_10      (clk_10),
    .soc_rst_ni  (soc_rst_no),
    .fan_level_i (fan_sw_i),
    .fan_pwm_o   (fan_pwm_o)
  );

  ////////////////////
  // SD card
  ////////////////////

  sd_pad_ctrl i_sd_pad_ctrl (
    .clk_10         (clk_10),
    .soc_rst_ni     (soc_rst_no),
    .spi_sck_i      (spi_sck_i),
    .spi_sck_en_i   (spi_sck_en_i),
    .spi_cs_i       (spi_cs_i),
    .spi_cs_en_i    (spi_cs_en_i),
    .spi_sd_i       (spi_sd_i),
    .spi_sd_en_i    (spi_sd_en_i),
    .spi_sd_o       (spi_sd_o),
    .sd_cd_i        (sd_cd_i),
    .sd_dat0_i      (sd_dat0_i),
    .sd_sclk_o      (sd_sclk_o),
    .sd_cmd_o       (sd_cmd_o),
    .sd_dat3_o      (sd_dat3_o),
    .card_present_o (card_present_o)
  );

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
////////////////////
// Testbench clock and board reset
////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
  parameter int HalfPeriod  = 10,
  parameter int ResetCycles = 3
) (
  output logic      clk_10,
  output logic      rst_n,
  input  wire logic rst_req_i
);

  logic por_n;

  initial begin
    clk_10 = 1'b0;
    forever #HalfPeriod clk_10 = ~clk_10;
  end

  // Power-on reset, later resets come from the request input
  initial begin
    por_n = 1'b0;
    repeat (ResetCycles) @(posedge clk_10);
    por_n <= 1'b1;
  end

  assign rst_n = por_n & ~rst_req_i;

endmodule

`default_nettype wire

/* testbench/tb_board_glue.sv */
////////////////////
// Board glue testbench
// Reset, boot strap, RTC, fan PWM and SD pad tests
////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_board_glue;

  localparam int SelReset  = 0;
  localparam int SelRtc    = 1;
  localparam int SelFan    = 2;
  localparam int SelCard   = 3;
  localparam int FanPeriod = 64;
  localparam int Seed      = 36;

  logic clk_10;
  logic rst_n;
  logic rst_req;
  logic dbg_reset_i;
  logic testmode_i;
  logic soc_rst_no;
  system_pkg::boot_mode_t boot_mode_i;
  system_pkg::boot_mode_t dbg_boot_mode_i;
  system_pkg::boot_mode_t boot_mode_safety_i;
  system_pkg::boot_mode_t dbg_boot_mode_safety_i;
  system_pkg::boot_mode_t boot_mode_o;
  system_pkg::boot_mode_t boot_mode_safety_o;
  logic rtc_clk_o;
  system_pkg::fan_level_t fan_sw_i;
  logic fan_pwm_o;
  logic spi_sck_i;
  logic spi_sck_en_i;
  pads_pkg::spi_cs_t spi_cs_i;
  pads_pkg::spi_cs_t spi_cs_en_i;
  pads_pkg::spi_lanes_t spi_sd_i;
  pads_pkg::spi_lanes_t spi_sd_en_i;
  pads_pkg::spi_lanes_t spi_sd_o;
  logic sd_cd_i;
  logic sd_dat0_i;
  logic sd_sclk_o;
  logic sd_cmd_o;
  logic sd_dat3_o;
  logic card_present_o;

  int errors;
  int checks;
  int tests_run;
  int tests_failed;
  int test_start_errors;
  logic [31:0] rng_state;

  tb_clock i_clock (
    .clk_10    (clk_10),
    .rst_n     (rst_n),
    .rst_req_i (rst_req)
  );

  board_glue_top dut (.*);

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic expect_true(input bit cond, input string msg);
    checks++;
    assert (cond) else begin
      $display("** Error at %0t ns: %s", $time, msg);
      errors++;
    end
  endtask

  function automatic logic probe(input int sel);
    case (sel)
      SelReset: return soc_rst_no;
      SelRtc:   return rtc_clk_o;
      SelFan:   return fan_pwm_o;
      default:  return card_present_o;
    endcase
  endfunction

  // Counts falling edges until the output reaches the level
  task automatic wait_for(input int sel, input logic level, input int limit, input string what,
                          output int cycles);
    cycles = 0;
    while (probe(sel) !== level && cycles < limit) begin
      @(negedge clk_10);
      cycles++;
    end
    if (probe(sel) !== level) begin
      $display("Timeout: %s did not reach %b within %0d cycles", what, level, limit);
      errors++;
    end
  endtask

  task automatic enter_reset();
    @(posedge clk_10);
    rst_req <= 1'b1;
    @(negedge clk_10);
  endtask

  task automatic leave_reset();
    int cycles;
    repeat (3) @(posedge clk_10);
    rst_req <= 1'b0;
    @(negedge clk_10);
    wait_for(SelReset, 1'b1, 10, "soc_rst_no", cycles);
  endtask

  task automatic start_test();
    test_start_errors = errors;
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == test_start_errors) begin
      $display("Test %-6s passed", name);
    end else begin
      tests_failed++;
      $display("Test %-6s failed with %0d errors", name, errors - test_start_errors);
    end
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_reset();
    int cycles;
    start_test();
    cycles = 0;
    @(posedge clk_10);
    @(negedge clk_10);
    while (!rst_n && cycles < 10) begin
      expect_true(soc_rst_no === 1'b0, "soc_rst_no high during board reset");
      @(negedge clk_10);
      cycles++;
    end
    if (!rst_n) begin
      $display("Timeout: board reset was never released");
      errors++;
    end
    wait_for(SelReset, 1'b1, 10, "soc_rst_no", cycles);
    expect_true(cycles == 2, $sformatf("soc_rst_no rose after %0d edges, expected 2", cycles));
    // Debug reset acts before the next clock edge
    @(posedge clk_10);
    dbg_reset_i <= 1'b1;
    @(negedge clk_10);
    expect_true(soc_rst_no === 1'b0, "dbg_reset_i did not drop soc_rst_no at once");
    @(posedge clk_10);
    dbg_reset_i <= 1'b0;
    @(negedge clk_10);
    wait_for(SelReset, 1'b1, 10, "soc_rst_no", cycles);
    expect_true(cycles == 2, $sformatf("debug release took %0d edges, expected 2", cycles));
    @(posedge clk_10);
    testmode_i <= 1'b1;
    rst_req    <= 1'b1;
    @(negedge clk_10);
    expect_true(soc_rst_no === 1'b0, "test mode soc_rst_no not low with rst_n low");
    @(posedge clk_10);
    rst_req <= 1'b0;
    @(negedge clk_10);
    expect_true(soc_rst_no === 1'b1, "test mode soc_rst_no not following rst_n");
    @(posedge clk_10);
    testmode_i <= 1'b0;
    @(negedge clk_10);
    wait_for(SelReset, 1'b1, 10, "soc_rst_no", cycles);
    report_test("reset");
  endtask

  task automatic test_boot();
    system_pkg::boot_mode_t exp_host;
    system_pkg::boot_mode_t exp_safety;
    logic [31:0] r;
    start_test();
    enter_reset();
    r = xorshift32();
    @(posedge clk_10);
    boot_mode_i            <= r[1:0];
    dbg_boot_mode_i        <= r[3:2];
    boot_mode_safety_i     <= r[5:4];
    dbg_boot_mode_safety_i <= r[7:6];
    exp_host   = r[1:0] | r[3:2];
    exp_safety = r[5:4] | r[7:6];
    @(negedge clk_10);
    expect_true(boot_mode_o === '0 && boot_mode_safety_o === '0, "boot outputs not 0 in reset");
    leave_reset();
    @(negedge clk_10);
    expect_true(boot_mode_o === exp_host,
                $sformatf("host boot mode %b, expected %b", boot_mode_o, exp_host));
    expect_true(boot_mode_safety_o === exp_safety,
                $sformatf("safety boot mode %b, expected %b", boot_mode_safety_o, exp_safety));
    // Straps change after capture
    r = xorshift32();
    @(posedge clk_10);
    boot_mode_i            <= r[1:0];
    dbg_boot_mode_i        <= r[3:2];
    boot_mode_safety_i     <= r[5:4];
    dbg_boot_mode_safety_i <= r[7:6];
    repeat (3) @(negedge clk_10);
    expect_true(boot_mode_o === exp_host && boot_mode_safety_o === exp_safety,
                "boot outputs changed after capture");
    report_test("boot");
  endtask

  task automatic test_rtc();
    int cycles;
    logic level;
    start_test();
    enter_reset();
    expect_true(rtc_clk_o === 1'b0, "rtc_clk_o not low in reset");
    leave_reset();
    expect_true(rtc_clk_o === 1'b0, "rtc_clk_o not low after reset");
    wait_for(SelRtc, 1'b1, 20, "rtc_clk_o", cycles);
    expect_true(cycles == 5, $sformatf("first rtc_clk_o rise after %0d cycles", cycles));
    level = 1'b1;
    repeat (4) begin
      level = ~level;
      wait_for(SelRtc, level, 20, "rtc_clk_o", cycles);
      expect_true(cycles == 5, $sformatf("rtc_clk_o phase of %0d cycles, expected 5", cycles));
    end
    report_test("rtc");
  endtask

  task automatic test_fan();
    int levels[6];
    int high;
    int cycles;
    start_test();
    levels[0] = 0;
    levels[1] = 15;
    for (int i = 2; i < 6; i++) begin
      levels[i] = int'(xorshift32() & 32'h0000_000f);
    end
    foreach (levels[i]) begin
      @(posedge clk_10);
      fan_sw_i <= system_pkg::fan_level_t'(levels[i]);
      // Two full periods so the new level is in effect
      repeat (2 * FanPeriod) @(negedge clk_10);
      if (levels[i] != 0) begin
        wait_for(SelFan, 1'b0, FanPeriod, "fan_pwm_o low", cycles);
        wait_for(SelFan, 1'b1, FanPeriod, "fan_pwm_o rise", cycles);
      end
      high = 0;
      repeat (FanPeriod) begin
        if (fan_pwm_o === 1'b1) begin
          high++;
        end
        @(negedge clk_10);
      end
      expect_true(high == levels[i] * 4,
                  $sformatf("level %0d gave %0d high cycles", levels[i], high));
    end
    report_test("fan");
  endtask

  task automatic test_sd();
    int cycles;
    logic [31:0] r;
    start_test();
    // Card present, all enables still low
    @(posedge clk_10);
    sd_cd_i      <= 1'b1;
    spi_sck_en_i <= 1'b0;
    spi_cs_en_i  <= '0;
    spi_sd_en_i  <= '0;
    @(negedge clk_10);
    wait_for(SelCard, 1'b1, 10, "card_present_o", cycles);
    expect_true(cycles == 2, $sformatf("card detect took %0d cycles, expected 2", cycles));
    expect_true(sd_sclk_o === 1'b1 && sd_cmd_o === 1'b1 && sd_dat3_o === 1'b1,
                "SD pins not idle high with enables low");
    @(posedge clk_10);
    spi_sck_en_i <= 1'b1;
    spi_cs_en_i  <= '1;
    spi_sd_en_i  <= '1;
    repeat (8) begin
      r = xorshift32();
      @(posedge clk_10);
      spi_sck_i <= r[0];
      spi_cs_i  <= r[2:1];
      spi_sd_i  <= r[6:3];
      @(negedge clk_10);
      expect_true(sd_sclk_o === spi_sck_i, "sd_sclk_o does not follow spi_sck_i");
      expect_true(sd_dat3_o === spi_cs_i[0], "sd_dat3_o does not follow chip select 0");
      expect_true(sd_cmd_o === spi_sd_i[0], "sd_cmd_o does not follow lane 0");
    end
    // No card, chip select forced inactive
    @(posedge clk_10);
    sd_cd_i  <= 1'b0;
    spi_cs_i <= '0;
    @(negedge clk_10);
    wait_for(SelCard, 1'b0, 10, "card_present_o low", cycles);
    expect_true(sd_dat3_o === 1'b1, "sd_dat3_o not high without a card");
    repeat (8) begin
      r = xorshift32();
      @(posedge clk_10);
      sd_dat0_i <= r[0];
      @(negedge clk_10);
      expect_true(spi_sd_o[1] === sd_dat0_i, "spi_sd_o lane 1 differs from sd_dat0_i");
      expect_true(spi_sd_o[3:2] === 2'b00 && spi_sd_o[0] === 1'b0,
                  $sformatf("spi_sd_o unused lanes not 0, got %b", spi_sd_o));
    end
    report_test("sd");
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    rng_state    = Seed;
    rst_req                <= 1'b0;
    dbg_reset_i            <= 1'b0;
    testmode_i             <= 1'b0;
    boot_mode_i            <= '0;
    dbg_boot_mode_i        <= '0;
    boot_mode_safety_i     <= '0;
    dbg_boot_mode_safety_i <= '0;
    fan_sw_i               <= '0;
    spi_sck_i              <= 1'b0;
    spi_sck_en_i           <= 1'b0;
    spi_cs_i               <= '0;
    spi_cs_en_i            <= '0;
    spi_sd_i               <= '0;
    spi_sd_en_i            <= '0;
    sd_cd_i                <= 1'b0;
    sd_dat0_i              <= 1'b0;
    test_reset();
    test_boot();
    test_rtc();
    test_fan();
    test_sd();
    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* board_glue_top.f */
verilog/system_pkg.sv
verilog/pads_pkg.sv
verilog/reset_sync.sv
verilog/boot_strap_latch.sv
verilog/rtc_divider.sv
verilog/fan_pwm.sv
verilog/sd_pad_ctrl.sv
verilog/board_glue_top.sv
testbench/tb_clock.sv
testbench/tb_board_glue.sv

/* Makefile */
# Verilator build and run for the board glue testbench

VERILATOR ?= verilator
TOP       ?= tb_board_glue
RTL_TOP   ?= board_glue_top
FILELIST  ?= board_glue_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ns
LINTFLAGS ?= --lint-only -Wall --timescale 1ns/1ns
RTL_SRCS  ?= $(shell grep '^verilog/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
